// File: src/agc_isa_pkg.sv
`default_nettype none

package agc_isa_pkg;

  // one instruction word, decoded two ways
  typedef union packed {
    struct packed {
      logic        spare;
      logic [2:0]  opcode;
      logic [11:0] k;
    } basic;
    struct packed {
      logic        spare;
      logic [2:0]  opcode;
      logic [1:0]  qc;
      logic [9:0]  k10;
    } quarter;
  } instr_word_t;

  // basic opcode field
  localparam logic [2:0] OPC_TC      = 3'd0;
  localparam logic [2:0] OPC_CCS     = 3'd1;
  localparam logic [2:0] OPC_DAS_GRP = 3'd2;
  localparam logic [2:0] OPC_CA      = 3'd3;
  localparam logic [2:0] OPC_CS      = 3'd4;
  localparam logic [2:0] OPC_IDX_GRP = 3'd5;
  localparam logic [2:0] OPC_AD      = 3'd6;
  localparam logic [2:0] OPC_MASK    = 3'd7;

  // k under opcode 0 that means EXTEND
  localparam logic [11:0] K_EXTEND  = 12'd6;
  // bits 11:9 of an extracode that mark EDRUPT
  localparam logic [2:0]  EDRUPT_PC = 3'd7;

  // internal operations
  localparam int OP_W = 4;
  localparam logic [OP_W-1:0] OP_NOP    = 4'd0;
  localparam logic [OP_W-1:0] OP_TC     = 4'd1;
  localparam logic [OP_W-1:0] OP_TCF    = 4'd2;
  localparam logic [OP_W-1:0] OP_CCS    = 4'd3;
  localparam logic [OP_W-1:0] OP_INCR   = 4'd4;
  localparam logic [OP_W-1:0] OP_ADS    = 4'd5;
  localparam logic [OP_W-1:0] OP_CA     = 4'd6;
  localparam logic [OP_W-1:0] OP_CS     = 4'd7;
  localparam logic [OP_W-1:0] OP_TS     = 4'd8;
  localparam logic [OP_W-1:0] OP_XCH    = 4'd9;
  localparam logic [OP_W-1:0] OP_AD     = 4'd10;
  localparam logic [OP_W-1:0] OP_MASK   = 4'd11;
  localparam logic [OP_W-1:0] OP_EXTEND = 4'd12;
  localparam logic [OP_W-1:0] OP_HALT   = 4'd13;

  // instruction cycle states
  localparam int ST_W = 4;
  localparam logic [ST_W-1:0] ST_RESET   = 4'd0;
  localparam logic [ST_W-1:0] ST_FETCH_0 = 4'd1;
  localparam logic [ST_W-1:0] ST_FETCH_1 = 4'd2;
  localparam logic [ST_W-1:0] ST_ZUPD_0  = 4'd3;
  localparam logic [ST_W-1:0] ST_ZUPD_1  = 4'd4;
  localparam logic [ST_W-1:0] ST_DECODE  = 4'd5;
  localparam logic [ST_W-1:0] ST_READ_0  = 4'd6;
  localparam logic [ST_W-1:0] ST_READ_1  = 4'd7;
  localparam logic [ST_W-1:0] ST_EXEC    = 4'd8;
  localparam logic [ST_W-1:0] ST_EXTRA_0 = 4'd9;
  localparam logic [ST_W-1:0] ST_EXTRA_1 = 4'd10;
  localparam logic [ST_W-1:0] ST_WB_0    = 4'd11;
  localparam logic [ST_W-1:0] ST_WB_1    = 4'd12;
  localparam logic [ST_W-1:0] ST_HALT    = 4'd13;

endpackage

`default_nettype wire

// File: src/agc_mem_pkg.sv
`default_nettype none

package agc_mem_pkg;

  // 15 value bits plus the overflow bit
  localparam int WORD_W    = 16;
  localparam int ADDR_W    = 12;
  localparam int MEM_DEPTH = 4096;
  // zero bits above an address held in a word
  localparam int PAD_W     = WORD_W - ADDR_W;

  // central registers at fixed low addresses
  localparam logic [ADDR_W-1:0] ADDR_A = 12'd0;
  localparam logic [ADDR_W-1:0] ADDR_Q = 12'd2;
  localparam logic [ADDR_W-1:0] ADDR_Z = 12'd5;

  // first fixed-memory word
  localparam logic [ADDR_W-1:0] START_ADDR = 12'o4000;

endpackage

`default_nettype wire

// File: src/agc_decode.sv
`default_nettype none

module agc_decode (
  input  agc_isa_pkg::instr_word_t        instr,
  input  logic                            extracode,
  output logic [agc_isa_pkg::OP_W-1:0]    op,
  output logic [agc_mem_pkg::ADDR_W-1:0]  operand_addr,
  output logic [agc_mem_pkg::ADDR_W-1:0]  dest_addr,
  output logic                            needs_read
);

  logic [agc_mem_pkg::ADDR_W-1:0] k;
  logic [agc_mem_pkg::ADDR_W-1:0] k10;
  logic [1:0]                     qc;

  assign k   = instr.basic.k;
  assign k10 = {2'b00, instr.quarter.k10};
  assign qc  = instr.quarter.qc;

  always_comb
  begin
    op           = agc_isa_pkg::OP_NOP;
    operand_addr = k;
    dest_addr    = agc_mem_pkg::ADDR_A;
    needs_read   = 1'b0;

    if (extracode)
    begin
      // only EDRUPT survives in extracode space
      if (instr.basic.opcode == agc_isa_pkg::OPC_TC && k[11:9] == agc_isa_pkg::EDRUPT_PC)
        op = agc_isa_pkg::OP_HALT;
    end
    else
    begin
      case (instr.basic.opcode)
        agc_isa_pkg::OPC_TC:
          if (k == agc_isa_pkg::K_EXTEND)
            op = agc_isa_pkg::OP_EXTEND;
          else
          begin
            op        = agc_isa_pkg::OP_TC;
            dest_addr = agc_mem_pkg::ADDR_Z;
          end
        agc_isa_pkg::OPC_CCS:
        begin
          dest_addr = agc_mem_pkg::ADDR_Z;
          // ccs on erasable, tcf on fixed
          if (qc == 2'd0)
          begin
            op           = agc_isa_pkg::OP_CCS;
            operand_addr = k10;
            needs_read   = 1'b1;
          end
          else
            op = agc_isa_pkg::OP_TCF;
        end
        agc_isa_pkg::OPC_DAS_GRP:
          if (qc[1])
          begin
            op           = qc[0] ? agc_isa_pkg::OP_ADS : agc_isa_pkg::OP_INCR;
            operand_addr = k10;
            dest_addr    = k10;
            needs_read   = 1'b1;
          end
        agc_isa_pkg::OPC_CA:
        begin
          op         = agc_isa_pkg::OP_CA;
          needs_read = 1'b1;
        end
        agc_isa_pkg::OPC_CS:
        begin
          op         = agc_isa_pkg::OP_CS;
          needs_read = 1'b1;
        end
        agc_isa_pkg::OPC_IDX_GRP:
        begin
          operand_addr = k10;
          if (qc == 2'd2)
          begin
            op        = agc_isa_pkg::OP_TS;
            dest_addr = k10;
          end
          else if (qc == 2'd3)
          begin
            // old A goes to k10 first, operand lands in A
            op         = agc_isa_pkg::OP_XCH;
            needs_read = 1'b1;
          end
        end
        agc_isa_pkg::OPC_AD:
        begin
          op         = agc_isa_pkg::OP_AD;
          needs_read = 1'b1;
        end
        default:
        begin
          op         = agc_isa_pkg::OP_MASK;
          needs_read = 1'b1;
        end
      endcase
    end

    // execute loads k as the operand when nothing is read
    assert final (!(needs_read === 1'b1 && op inside {agc_isa_pkg::OP_HALT,
                    agc_isa_pkg::OP_EXTEND, agc_isa_pkg::OP_TCF}));
  end

endmodule

`default_nettype wire

// File: src/agc_result.sv
`default_nettype none

module agc_result (
  input  logic [agc_isa_pkg::OP_W-1:0]    op,
  input  logic [agc_mem_pkg::WORD_W-1:0]  operand,
  input  logic [agc_mem_pkg::WORD_W-1:0]  reg_a,
  input  logic [agc_mem_pkg::ADDR_W-1:0]  reg_z,
  output logic [agc_mem_pkg::WORD_W-1:0]  result_value,
  output logic [agc_mem_pkg::WORD_W-1:0]  ccs_a,
  output logic [agc_mem_pkg::ADDR_W-1:0]  branch_z
);

  logic [15:0] raw_sum;
  logic [14:0] eac_sum;
  logic        add_ovf;
  logic        opnd_pos_zero;
  logic        opnd_neg_zero;

  // ones' complement add, carry out wraps to bit 0
  assign raw_sum = {1'b0, reg_a[14:0]} + {1'b0, operand[14:0]};
  assign eac_sum = raw_sum[14:0] + {14'd0, raw_sum[15]};
  // same input signs, other result sign
  assign add_ovf = (reg_a[14] == operand[14]) && (eac_sum[14] != operand[14]);

  assign opnd_pos_zero = (operand[14:0] == 15'h0000);
  assign opnd_neg_zero = (operand[14:0] == 15'h7fff);

  always_comb
  begin
    ccs_a    = '0;
    branch_z = reg_z;
    case (op)
      agc_isa_pkg::OP_TC, agc_isa_pkg::OP_TCF:
        branch_z = operand[agc_mem_pkg::ADDR_W-1:0];
      agc_isa_pkg::OP_CCS:
        // reg_z already points past the CCS word
        if (!operand[14])
        begin
          if (opnd_pos_zero)
            branch_z = reg_z + 12'd1;
          else
            ccs_a = {1'b0, operand[14:0] - 15'd1};
        end
        else if (opnd_neg_zero)
          branch_z = reg_z + 12'd3;
        else
        begin
          branch_z = reg_z + 12'd2;
          ccs_a    = {1'b0, ~operand[14:0] - 15'd1};
        end
      default: ;
    endcase
  end

  always_comb
  begin
    case (op)
      agc_isa_pkg::OP_AD, agc_isa_pkg::OP_ADS: result_value = {add_ovf, eac_sum};
      agc_isa_pkg::OP_INCR: result_value = operand + 16'd1;
      agc_isa_pkg::OP_CS:   result_value = {1'b0, ~operand[14:0]};
      agc_isa_pkg::OP_MASK: result_value = {1'b0, operand[14:0] & reg_a[14:0]};
      agc_isa_pkg::OP_TS:   result_value = reg_a;
      default:              result_value = operand;
    endcase
  end

endmodule

`default_nettype wire

// File: src/agc_execute.sv
`default_nettype none

module agc_execute (
  input  logic                            raw_clk,
  input  logic                            button_reset,
  input  logic [agc_mem_pkg::WORD_W-1:0]  mem_rdata,
  input  logic [agc_mem_pkg::WORD_W-1:0]  reg_a,
  input  logic [agc_mem_pkg::ADDR_W-1:0]  reg_z,
  input  logic [agc_isa_pkg::OP_W-1:0]    op,
  input  logic [agc_mem_pkg::ADDR_W-1:0]  operand_addr,
  input  logic [agc_mem_pkg::ADDR_W-1:0]  dest_addr,
  input  logic                            needs_read,
  input  logic [agc_mem_pkg::WORD_W-1:0]  result_value,
  input  logic [agc_mem_pkg::WORD_W-1:0]  ccs_a,
  input  logic [agc_mem_pkg::ADDR_W-1:0]  branch_z,
  output agc_isa_pkg::instr_word_t        instr,
  output logic                            extracode,
  output logic [agc_mem_pkg::WORD_W-1:0]  operand,
  output logic                            mem_en,
  output logic                            mem_we,
  output logic [agc_mem_pkg::ADDR_W-1:0]  mem_addr,
  output logic [agc_mem_pkg::WORD_W-1:0]  mem_wdata,
  output logic                            halted
);

  logic [agc_isa_pkg::ST_W-1:0]   state;
  logic [agc_mem_pkg::WORD_W-1:0] wb_data;
  logic [agc_mem_pkg::ADDR_W-1:0] z_next;
  logic [agc_mem_pkg::ADDR_W-1:0] extra_addr;
  logic [agc_mem_pkg::WORD_W-1:0] extra_data;
  logic                           is_branch;
  logic                           needs_extra;

  assign z_next      = reg_z + 12'd1;
  assign halted      = (state == agc_isa_pkg::ST_HALT);
  assign is_branch   = op inside {agc_isa_pkg::OP_TC, agc_isa_pkg::OP_TCF, agc_isa_pkg::OP_CCS};
  assign needs_extra = op inside {agc_isa_pkg::OP_TC, agc_isa_pkg::OP_CCS,
                                  agc_isa_pkg::OP_XCH, agc_isa_pkg::OP_ADS};

  // second write for ops that touch two words
  always_comb
  begin
    case (op)
      agc_isa_pkg::OP_TC:
      begin
        extra_addr = agc_mem_pkg::ADDR_Q;
        extra_data = {{agc_mem_pkg::PAD_W{1'b0}}, reg_z};
      end
      agc_isa_pkg::OP_CCS:
      begin
        extra_addr = agc_mem_pkg::ADDR_A;
        extra_data = ccs_a;
      end
      agc_isa_pkg::OP_XCH:
      begin
        extra_addr = operand_addr;
        extra_data = reg_a;
      end
      default:
      begin
        // ads copies the sum into A
        extra_addr = agc_mem_pkg::ADDR_A;
        extra_data = wb_data;
      end
    endcase
  end

  always_comb
  begin
    mem_en    = 1'b0;
    mem_we    = 1'b0;
    mem_addr  = reg_z;
    mem_wdata = wb_data;
    case (state)
      agc_isa_pkg::ST_FETCH_0:
        mem_en = 1'b1;
      agc_isa_pkg::ST_ZUPD_0:
      begin
        mem_en    = 1'b1;
        mem_we    = 1'b1;
        mem_addr  = agc_mem_pkg::ADDR_Z;
        mem_wdata = {{agc_mem_pkg::PAD_W{1'b0}}, z_next};
      end
      agc_isa_pkg::ST_READ_0:
      begin
        mem_en   = 1'b1;
        mem_addr = operand_addr;
      end
      agc_isa_pkg::ST_EXTRA_0:
      begin
        mem_en    = 1'b1;
        mem_we    = 1'b1;
        mem_addr  = extra_addr;
        mem_wdata = extra_data;
      end
      agc_isa_pkg::ST_WB_0:
      begin
        mem_en   = 1'b1;
        mem_we   = 1'b1;
        mem_addr = dest_addr;
      end
      default: ;
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state     <= agc_isa_pkg::ST_RESET;
      extracode <= 1'b0;
    end
    else
    begin
      case (state)
        agc_isa_pkg::ST_RESET:   state <= agc_isa_pkg::ST_FETCH_0;
        agc_isa_pkg::ST_FETCH_0: state <= agc_isa_pkg::ST_FETCH_1;
        agc_isa_pkg::ST_FETCH_1: state <= agc_isa_pkg::ST_ZUPD_0;
        agc_isa_pkg::ST_ZUPD_0:  state <= agc_isa_pkg::ST_ZUPD_1;
        agc_isa_pkg::ST_ZUPD_1:  state <= agc_isa_pkg::ST_DECODE;
        agc_isa_pkg::ST_DECODE:
        begin
          // flag lives for exactly one following instruction
          extracode <= (op == agc_isa_pkg::OP_EXTEND);
          if (op == agc_isa_pkg::OP_HALT)
            state <= agc_isa_pkg::ST_HALT;
          else if (op == agc_isa_pkg::OP_EXTEND || op == agc_isa_pkg::OP_NOP)
            state <= agc_isa_pkg::ST_FETCH_0;
          else if (needs_read)
            state <= agc_isa_pkg::ST_READ_0;
          else
            state <= agc_isa_pkg::ST_EXEC;
        end
        agc_isa_pkg::ST_READ_0:  state <= agc_isa_pkg::ST_READ_1;
        agc_isa_pkg::ST_READ_1:  state <= agc_isa_pkg::ST_EXEC;
        agc_isa_pkg::ST_EXEC:
          state <= needs_extra ? agc_isa_pkg::ST_EXTRA_0 : agc_isa_pkg::ST_WB_0;
        agc_isa_pkg::ST_EXTRA_0: state <= agc_isa_pkg::ST_EXTRA_1;
        agc_isa_pkg::ST_EXTRA_1: state <= agc_isa_pkg::ST_WB_0;
        agc_isa_pkg::ST_WB_0:    state <= agc_isa_pkg::ST_WB_1;
        agc_isa_pkg::ST_WB_1:    state <= agc_isa_pkg::ST_FETCH_0;
        agc_isa_pkg::ST_HALT:    state <= agc_isa_pkg::ST_HALT;
        default:                 state <= agc_isa_pkg::ST_RESET;
      endcase
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (state == agc_isa_pkg::ST_FETCH_1)
      instr <= mem_rdata;
    // k itself is the operand of tc and tcf
    if (state == agc_isa_pkg::ST_DECODE)
      operand <= {{agc_mem_pkg::PAD_W{1'b0}}, operand_addr};
    if (state == agc_isa_pkg::ST_READ_1)
      operand <= mem_rdata;
    // latched before the extra write can change A
    if (state == agc_isa_pkg::ST_EXEC)
      wb_data <= is_branch ? {{agc_mem_pkg::PAD_W{1'b0}}, branch_z} : result_value;
  end

  assert property (@(posedge raw_clk) disable iff (!button_reset) mem_we |-> mem_en);

  // halt is sticky and the bus stays quiet
  assert property (@(posedge raw_clk) disable iff (!button_reset)
    halted |=> halted && !mem_en);

endmodule

`default_nettype wire

// File: src/agc_memory.sv
`default_nettype none

module agc_memory (
  input  logic                            raw_clk,
  input  logic                            button_reset,
  input  logic                            mem_en,
  input  logic                            mem_we,
  input  logic [agc_mem_pkg::ADDR_W-1:0]  mem_addr,
  input  logic [agc_mem_pkg::WORD_W-1:0]  mem_wdata,
  output logic [agc_mem_pkg::WORD_W-1:0]  mem_rdata,
  input  logic                            load_we,
  input  logic [agc_mem_pkg::ADDR_W-1:0]  load_addr,
  input  logic [agc_mem_pkg::WORD_W-1:0]  load_data,
  output logic [agc_mem_pkg::WORD_W-1:0]  reg_a,
  output logic [agc_mem_pkg::WORD_W-1:0]  reg_q,
  output logic [agc_mem_pkg::ADDR_W-1:0]  reg_z
);

  logic [agc_mem_pkg::WORD_W-1:0] ram [agc_mem_pkg::MEM_DEPTH];
  logic                           bus_write;

  assign bus_write = mem_en && mem_we;

  // A, Q and Z shadow their addresses
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      reg_a <= '0;
      reg_q <= '0;
      reg_z <= agc_mem_pkg::START_ADDR;
    end
    else if (bus_write)
    begin
      case (mem_addr)
        agc_mem_pkg::ADDR_A: reg_a <= mem_wdata;
        agc_mem_pkg::ADDR_Q: reg_q <= mem_wdata;
        agc_mem_pkg::ADDR_Z: reg_z <= mem_wdata[agc_mem_pkg::ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge raw_clk)
  begin
    // program load only while the core sits in reset
    if (!button_reset && load_we)
      ram[load_addr] <= load_data;
    else if (bus_write)
      ram[mem_addr] <= mem_wdata;

    if (mem_en && !mem_we)
    begin
      case (mem_addr)
        agc_mem_pkg::ADDR_A: mem_rdata <= reg_a;
        agc_mem_pkg::ADDR_Q: mem_rdata <= reg_q;
        agc_mem_pkg::ADDR_Z: mem_rdata <= {{agc_mem_pkg::PAD_W{1'b0}}, reg_z};
        default:             mem_rdata <= ram[mem_addr];
      endcase
    end
  end

  assert property (@(posedge raw_clk) load_we |-> !button_reset);

endmodule

`default_nettype wire

// File: src/agc_core.sv
`default_nettype none

module agc_core (
  input  logic                            raw_clk,
  input  logic                            button_reset,
  input  logic                            load_we,
  input  logic [agc_mem_pkg::ADDR_W-1:0]  load_addr,
  input  logic [agc_mem_pkg::WORD_W-1:0]  load_data,
  output logic [agc_mem_pkg::WORD_W-1:0]  acc,
  output logic [agc_mem_pkg::ADDR_W-1:0]  pc,
  output logic                            halted
);

  logic                           mem_en;
  logic                           mem_we;
  logic [agc_mem_pkg::ADDR_W-1:0] mem_addr;
  logic [agc_mem_pkg::WORD_W-1:0] mem_wdata;
  logic [agc_mem_pkg::WORD_W-1:0] mem_rdata;
  agc_isa_pkg::instr_word_t       instr;
  logic                           extracode;
  logic [agc_mem_pkg::WORD_W-1:0] operand;
  logic [agc_isa_pkg::OP_W-1:0]   op;
  logic [agc_mem_pkg::ADDR_W-1:0] operand_addr;
  logic [agc_mem_pkg::ADDR_W-1:0] dest_addr;
  logic                           needs_read;
  logic [agc_mem_pkg::WORD_W-1:0] result_value;
  logic [agc_mem_pkg::WORD_W-1:0] ccs_a;
  logic [agc_mem_pkg::ADDR_W-1:0] branch_z;

  agc_execute execute_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_rdata    (mem_rdata),
    .reg_a        (acc),
    .reg_z        (pc),
    .op           (op),
    .operand_addr (operand_addr),
    .dest_addr    (dest_addr),
    .needs_read   (needs_read),
    .result_value (result_value),
    .ccs_a        (ccs_a),
    .branch_z     (branch_z),
    .instr        (instr),
    .extracode    (extracode),
    .operand      (operand),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .halted       (halted)
  );

  agc_decode decode_i (
    .instr        (instr),
    .extracode    (extracode),
    .op           (op),
    .operand_addr (operand_addr),
    .dest_addr    (dest_addr),
    .needs_read   (needs_read)
  );

  agc_result result_i (
    .op           (op),
    .operand      (operand),
    .reg_a        (acc),
    .reg_z        (pc),
    .result_value (result_value),
    .ccs_a        (ccs_a),
    .branch_z     (branch_z)
  );

  // Q is only reached through the bus
  agc_memory memory_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .load_we      (load_we),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .reg_a        (acc),
    .reg_q        (),
    .reg_z        (pc)
  );

endmodule

`default_nettype wire

// File: tb/tb_agc.sv
`default_nettype none

module tb_agc;

  localparam logic [11:0] START  = agc_mem_pkg::START_ADDR;
  localparam logic [11:0] DATA_X = 12'h100;
  localparam logic [11:0] DATA_Y = 12'h101;
  localparam logic [11:0] DATA_M = 12'h102;
  localparam logic [11:0] DATA_N = 12'h103;
  localparam logic [11:0] DATA_P = 12'h104;
  localparam logic [11:0] DATA_K = 12'h105;
  localparam logic [11:0] DATA_C = 12'h106;
  localparam logic [11:0] MARKER = 12'h110;
  localparam int HALT_TIMEOUT = 300;
  localparam int HOLD_CYCLES  = 20;

  logic                           raw_clk;
  logic                           button_reset;
  logic                           load_we;
  logic [agc_mem_pkg::ADDR_W-1:0] load_addr;
  logic [agc_mem_pkg::WORD_W-1:0] load_data;
  logic [agc_mem_pkg::WORD_W-1:0] acc;
  logic [agc_mem_pkg::ADDR_W-1:0] pc;
  logic                           halted;
  logic [31:0]                    rng;
  logic [11:0]                    prog_addr[$];
  logic [15:0]                    prog_data[$];

  agc_core dut_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .load_we      (load_we),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .acc          (acc),
    .pc           (pc),
    .halted       (halted)
  );

  initial
  begin
    raw_clk = 1'b0;
    forever #5 raw_clk = ~raw_clk;
  end

  // registers settle one cycle after reset is seen low
  assert property (@(posedge raw_clk) !button_reset |=>
    (acc == '0 && pc == agc_mem_pkg::START_ADDR && !halted))
  else
  begin
    $display("ERROR t=%0t reset acc=%h (expected 0000) pc=%h (expected %h) halted=%b (expected 0)",
             $time, $sampled(acc), $sampled(pc), agc_mem_pkg::START_ADDR, $sampled(halted));
    $display("Test failed");
    $fatal(1, "stopping at first error");
  end

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [15:0] rand_word();
    logic [31:0] r;
    r = xorshift32();
    return {1'b0, r[14:0]};
  endfunction

  // 15-bit ones' complement sum, bit 15 flags overflow
  function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
    logic [15:0] wide;
    logic [14:0] sum;
    logic        ovf;
    wide = {1'b0, a[14:0]} + {1'b0, b[14:0]};
    if (wide[15])
      sum = wide[14:0] + 15'd1;
    else
      sum = wide[14:0];
    ovf = (a[14] == b[14]) && (sum[14] != a[14]);
    return {ovf, sum};
  endfunction

  function automatic logic [15:0] basic_word(input logic [2:0] opc, input logic [11:0] k);
    agc_isa_pkg::instr_word_t w;
    w.basic.spare  = 1'b0;
    w.basic.opcode = opc;
    w.basic.k      = k;
    return w;
  endfunction

  function automatic logic [15:0] quarter_word(input logic [2:0] opc, input logic [1:0] qc,
                                               input logic [11:0] addr);
    agc_isa_pkg::instr_word_t w;
    w.quarter.spare  = 1'b0;
    w.quarter.opcode = opc;
    w.quarter.qc     = qc;
    w.quarter.k10    = addr[9:0];
    return w;
  endfunction

  task automatic put_word(input logic [11:0] addr, input logic [15:0] data);
    prog_addr.push_back(addr);
    prog_data.push_back(data);
  endtask

  // EXTEND then EDRUPT
  task automatic place_halt(input logic [11:0] addr);
    put_word(addr, basic_word(agc_isa_pkg::OPC_TC, agc_isa_pkg::K_EXTEND));
    put_word(addr + 12'd1, basic_word(agc_isa_pkg::OPC_TC, {agc_isa_pkg::EDRUPT_PC, 9'd0}));
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    assert (actual === expected)
    else
    begin
      $display("ERROR t=%0t %s = %h, expected %h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic run_and_check(input logic [15:0] exp_acc, input logic [11:0] exp_pc);
    int i;
    int cycles;
    @(posedge raw_clk);
    #1;
    button_reset = 1'b0;
    for (i = 0; i < prog_addr.size(); i++)
    begin
      load_we   = 1'b1;
      load_addr = prog_addr[i];
      load_data = prog_data[i];
      @(posedge raw_clk);
      #1;
    end
    load_we = 1'b0;
    prog_addr.delete();
    prog_data.delete();
    repeat (8) @(posedge raw_clk);
    #1;
    button_reset = 1'b1;
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT)
    begin
      @(posedge raw_clk);
      #1;
      cycles++;
    end
    if (!halted)
    begin
      $display("halted did not rise within %0d cycles after reset release", HALT_TIMEOUT);
      $display("Test failed");
      $fatal(1, "timeout");
    end
    else
    begin
      check_value("acc", acc, exp_acc);
      check_value("pc", {4'd0, pc}, {4'd0, exp_pc});
      // nothing moves while halted
      for (i = 0; i < HOLD_CYCLES; i++)
      begin
        @(posedge raw_clk);
        #1;
        check_value("acc", acc, exp_acc);
        check_value("pc", {4'd0, pc}, {4'd0, exp_pc});
        check_value("halted", {15'd0, halted}, 16'd1);
      end
    end
  endtask

  task automatic add_case(input logic [15:0] x, input logic [15:0] y);
    put_word(DATA_X, x);
    put_word(DATA_Y, y);
    put_word(START, basic_word(agc_isa_pkg::OPC_CA, DATA_X));
    put_word(START + 12'd1, basic_word(agc_isa_pkg::OPC_AD, DATA_Y));
    place_halt(START + 12'd2);
    run_and_check(ones_add(x, y), START + 12'd4);
  endtask

  task automatic incr_ads_case(input logic [15:0] x, input logic [15:0] y);
    put_word(DATA_X, x);
    put_word(DATA_M, y);
    put_word(START, basic_word(agc_isa_pkg::OPC_CA, DATA_X));
    put_word(START + 12'd1, quarter_word(agc_isa_pkg::OPC_DAS_GRP, 2'd2, DATA_M));
    put_word(START + 12'd2, quarter_word(agc_isa_pkg::OPC_DAS_GRP, 2'd3, DATA_M));
    put_word(START + 12'd3, basic_word(agc_isa_pkg::OPC_CA, DATA_M));
    place_halt(START + 12'd4);
    run_and_check(ones_add(x, y + 16'd1), START + 12'd6);
  endtask

  task automatic cs_mask_case(input logic [15:0] x, input logic [15:0] y);
    put_word(DATA_X, x);
    put_word(DATA_Y, y);
    put_word(START, basic_word(agc_isa_pkg::OPC_CS, DATA_X));
    put_word(START + 12'd1, basic_word(agc_isa_pkg::OPC_MASK, DATA_Y));
    place_halt(START + 12'd2);
    run_and_check({1'b0, ~x[14:0] & y[14:0]}, START + 12'd4);
  endtask

  // n ends up holding x, so the last AD doubles x
  task automatic store_xch_case(input logic [15:0] x, input logic [15:0] y);
    put_word(DATA_X, x);
    put_word(DATA_N, y);
    put_word(START, basic_word(agc_isa_pkg::OPC_CA, DATA_X));
    put_word(START + 12'd1, quarter_word(agc_isa_pkg::OPC_IDX_GRP, 2'd2, DATA_M));
    put_word(START + 12'd2, quarter_word(agc_isa_pkg::OPC_IDX_GRP, 2'd3, DATA_N));
    put_word(START + 12'd3, basic_word(agc_isa_pkg::OPC_CA, DATA_M));
    put_word(START + 12'd4, basic_word(agc_isa_pkg::OPC_AD, DATA_N));
    place_halt(START + 12'd5);
    run_and_check(ones_add(x, x), START + 12'd7);
  endtask

  task automatic tcf_case();
    put_word(DATA_P, 16'h1555);
    put_word(DATA_K, 16'h2aaa);
    put_word(START, basic_word(agc_isa_pkg::OPC_CCS, START + 12'd4));
    put_word(START + 12'd1, basic_word(agc_isa_pkg::OPC_CA, DATA_P));
    place_halt(START + 12'd2);
    put_word(START + 12'd4, basic_word(agc_isa_pkg::OPC_CA, DATA_K));
    place_halt(START + 12'd5);
    run_and_check(16'h2aaa, START + 12'd7);
  endtask

  // target reads Q back, which holds the return address
  task automatic tc_case();
    put_word(DATA_P, 16'h1555);
    put_word(START, basic_word(agc_isa_pkg::OPC_TC, START + 12'd8));
    put_word(START + 12'd1, basic_word(agc_isa_pkg::OPC_CA, DATA_P));
    place_halt(START + 12'd2);
    put_word(START + 12'd8, basic_word(agc_isa_pkg::OPC_CA, agc_mem_pkg::ADDR_Q));
    place_halt(START + 12'd9);
    run_and_check({4'd0, START + 12'd1}, START + 12'd11);
  endtask

  task automatic ccs_case(input logic [15:0] v);
    int          i;
    int          path;
    logic [15:0] new_a;
    logic [11:0] handler;
    // path is the slot offset past the CCS word
    if (!v[14] && v[14:0] == 15'd0)
    begin
      path  = 1;
      new_a = '0;
    end
    else if (!v[14])
    begin
      path  = 0;
      new_a = {1'b0, v[14:0] - 15'd1};
    end
    else if (v[14:0] == 15'h7fff)
    begin
      path  = 3;
      new_a = '0;
    end
    else
    begin
      path  = 2;
      // magnitude of a negative word is its distance from -0
      new_a = {1'b0, 15'h7fff - v[14:0] - 15'd1};
    end
    put_word(DATA_C, v);
    put_word(START, quarter_word(agc_isa_pkg::OPC_CCS, 2'd0, DATA_C));
    for (i = 0; i < 4; i++)
    begin
      handler = START + 12'd8 + 12'(4 * i);
      put_word(START + 12'(i + 1), basic_word(agc_isa_pkg::OPC_CCS, handler));
      put_word(MARKER + 12'(i), 16'(256 * (i + 1)));
      put_word(handler, basic_word(agc_isa_pkg::OPC_AD, MARKER + 12'(i)));
      place_halt(handler + 12'd1);
    end
    run_and_check(ones_add(new_a, 16'(256 * (path + 1))), START + 12'd11 + 12'(4 * path));
  endtask

  initial
  begin
    int n;
    button_reset = 1'b0;
    load_we      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    rng          = 32'hfbc3;

    // end-around carry and overflow corners first
    add_case(16'h7ffe, 16'h0003);
    add_case(16'h4000, 16'h4000);
    for (n = 0; n < 4; n++)
      add_case(rand_word(), rand_word());
    for (n = 0; n < 3; n++)
      incr_ads_case(rand_word(), rand_word());
    for (n = 0; n < 3; n++)
      cs_mask_case(rand_word(), rand_word());
    for (n = 0; n < 3; n++)
      store_xch_case(rand_word(), rand_word());

    tcf_case();
    tc_case();
    ccs_case(16'h0000);
    ccs_case(16'd1 + (rand_word() % 16'h3fff));
    ccs_case(16'h7fff);
    ccs_case(16'h4000 | (rand_word() % 16'h3fff));

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
src/agc_isa_pkg.sv
src/agc_mem_pkg.sv
src/agc_decode.sv
src/agc_result.sv
src/agc_execute.sv
src/agc_memory.sv
src/agc_core.sv
tb/tb_agc.sv

// File: Bender.yml
package:
  name: agc_core

sources:
  - src/agc_isa_pkg.sv
  - src/agc_mem_pkg.sv
  - src/agc_decode.sv
  - src/agc_result.sv
  - src/agc_execute.sv
  - src/agc_memory.sv
  - src/agc_core.sv
  - target: test
    files:
      - tb/tb_agc.sv
